//--- source/receiver_pkg.sv
// Shared definitions for the decimating receive chain
// Sample widths, variable CIC rate limits, FIR coefficient table
// and the bit growth helper used by both CIC decimators

package receiver_pkg;

  // ------------------------------
  // Sample widths
  localparam int mix_width   = 18;
  localparam int stage_width = 16;
  localparam int out_width   = 24;

  // ------------------------------
  // Variable CIC rate range
  localparam int rate_min   = 2;
  localparam int rate_max   = 16;
  localparam int rate_width = 5;

  // ------------------------------
  // Decimate-by-two FIR
  localparam int fir_taps   = 11;
  localparam int coef_width = 18;
  localparam int fir_shift  = 9;

  // Symmetric lowpass, 17 fraction bits, sums to 2**17 for unity DC gain
  localparam logic signed [coef_width-1:0] fir_coefs [fir_taps] = '{
    -18'sd640, -18'sd1536, 18'sd2304, 18'sd12288, 18'sd27136,
    18'sd51968,
    18'sd27136, 18'sd12288, 18'sd2304, -18'sd1536, -18'sd640
  };

  // Ceiling of log2, zero for rates of 0 and 1
  function automatic int clog2_rate(input int rate);
    int result;
    result = 0;
    for (int i = 0; i < 31; i++) begin
      if ((1 << i) < rate) begin
        result = i + 1;
      end
    end
    return result;
  endfunction

endpackage

//--- source/cic_decimator.sv
// Fixed-rate CIC decimator for one channel
// STAGES integrators run on every in_strobe, STAGES combs on every
// DECIMATION-th strobe, output is the top bits of the last comb

`timescale 1ns/1ns

module cic_decimator #(
  parameter int STAGES     = 3,
  parameter int DECIMATION = 5,
  parameter int IN_WIDTH   = 18,
  parameter int OUT_WIDTH  = 16
) (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        in_strobe,
  input  logic signed [IN_WIDTH-1:0]  in_data,
  output logic                        out_strobe,
  output logic signed [OUT_WIDTH-1:0] out_data
);

  import receiver_pkg::*;

  // Growth is ceil(STAGES * log2(DECIMATION)), 25 bits for 18 in at rate 5
  localparam int ACC_W = IN_WIDTH + clog2_rate(DECIMATION ** STAGES);
  localparam int CNT_W = clog2_rate(DECIMATION);

  logic signed [ACC_W-1:0] ext_in;
  logic signed [ACC_W-1:0] integ      [STAGES];
  logic signed [ACC_W-1:0] integ_next [STAGES];
  logic signed [ACC_W-1:0] comb_dly   [STAGES];
  logic signed [ACC_W-1:0] comb_val   [STAGES+1];
  logic        [CNT_W-1:0] count;
  logic                    decim;

  assign ext_in = ACC_W'(in_data);

  // Last strobe of each window fires the combs
  assign decim = in_strobe && (count == CNT_W'(DECIMATION - 1));

  always_ff @(posedge clock) begin
    if (reset) begin
      count <= '0;
    end else if (in_strobe) begin
      count <= decim ? '0 : count + 1'b1;
    end
  end

  // ------------------------------
  // Integrators, chained so the comb sees the current sample
  // Comb section runs on the final integrator value
  assign comb_val[0] = integ_next[STAGES-1];

  for (genvar g = 0; g < STAGES; g++) begin : g_stage
    if (g == 0) begin : g_first
      assign integ_next[g] = integ[g] + ext_in;
    end else begin : g_rest
      assign integ_next[g] = integ[g] + integ_next[g-1];
    end

    // Differential delay of one decimated sample
    assign comb_val[g+1] = comb_val[g] - comb_dly[g];

    always_ff @(posedge clock) begin
      if (reset) begin
        integ[g]    <= '0;
        comb_dly[g] <= '0;
      end else begin
        if (in_strobe) begin
          integ[g] <= integ_next[g];
        end
        if (decim) begin
          comb_dly[g] <= comb_val[g];
        end
      end
    end
  end

  // ------------------------------
  // Output register, one cycle after the completing strobe
  always_ff @(posedge clock) begin
    if (reset) begin
      out_strobe <= 1'b0;
      out_data   <= '0;
    end else begin
      out_strobe <= decim;
      if (decim) begin
        out_data <= comb_val[STAGES][ACC_W-1 -: OUT_WIDTH];
      end
    end
  end

  // Decimated output never runs back to back
  assert property (@(posedge clock) disable iff (reset) out_strobe |=> !out_strobe);

endmodule

//--- source/variable_cic_decimator.sv
// CIC decimator for one channel with runtime rate
// Rate is taken between rate_min and rate_max, the output is scaled
// back by an arithmetic shift of STAGES * ceil(log2(rate))

`timescale 1ns/1ns

module variable_cic_decimator #(
  parameter int STAGES    = 5,
  parameter int IN_WIDTH  = 16,
  parameter int OUT_WIDTH = 16
) (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic                                 in_strobe,
  input  logic [receiver_pkg::rate_width-1:0]  rate,
  input  logic signed [IN_WIDTH-1:0]           in_data,
  output logic                                 out_strobe,
  output logic signed [OUT_WIDTH-1:0]          out_data
);

  import receiver_pkg::*;

  // Sized for the worst case rate, 36 bits for 16 in and 5 stages
  localparam int ACC_W     = IN_WIDTH + STAGES * clog2_rate(rate_max);
  localparam int MAX_SHIFT = STAGES * clog2_rate(rate_max);
  localparam int SHIFT_W   = $clog2(MAX_SHIFT + 1);

  logic signed [ACC_W-1:0]      ext_in;
  logic signed [ACC_W-1:0]      integ      [STAGES];
  logic signed [ACC_W-1:0]      integ_next [STAGES];
  logic signed [ACC_W-1:0]      comb_dly   [STAGES];
  logic signed [ACC_W-1:0]      comb_val   [STAGES+1];
  logic signed [ACC_W-1:0]      scaled;
  logic        [SHIFT_W-1:0]    gain_shift;
  logic        [rate_width-1:0] count;
  logic                         decim;

  assign ext_in = ACC_W'(in_data);

  // Counter wraps at rate, changes of rate go with a reset of the chain
  assign decim = in_strobe && (count == rate - 1'b1);

  always_ff @(posedge clock) begin
    if (reset) begin
      count <= '0;
    end else if (in_strobe) begin
      count <= decim ? '0 : count + 1'b1;
    end
  end

  // ------------------------------
  // Integrator and comb cascade
  assign comb_val[0] = integ_next[STAGES-1];

  for (genvar g = 0; g < STAGES; g++) begin : g_stage
    if (g == 0) begin : g_first
      assign integ_next[g] = integ[g] + ext_in;
    end else begin : g_rest
      assign integ_next[g] = integ[g] + integ_next[g-1];
    end

    assign comb_val[g+1] = comb_val[g] - comb_dly[g];

    always_ff @(posedge clock) begin
      if (reset) begin
        integ[g]    <= '0;
        comb_dly[g] <= '0;
      end else begin
        if (in_strobe) begin
          integ[g] <= integ_next[g];
        end
        if (decim) begin
          comb_dly[g] <= comb_val[g];
        end
      end
    end
  end

  // ------------------------------
  // Gain rate**STAGES never exceeds 2**gain_shift, so the
  // truncation below keeps the sign
  assign gain_shift = SHIFT_W'(STAGES * clog2_rate(int'(rate)));
  assign scaled     = comb_val[STAGES] >>> gain_shift;

  always_ff @(posedge clock) begin
    if (reset) begin
      out_strobe <= 1'b0;
      out_data   <= '0;
    end else begin
      out_strobe <= decim;
      if (decim) begin
        out_data <= scaled[OUT_WIDTH-1:0];
      end
    end
  end

  // Rate is driven from the top and must stay in the legal range
  assert property (@(posedge clock) !reset |-> (rate >= rate_min) && (rate <= rate_max));

endmodule

//--- source/decimating_fir.sv
// Complex decimate-by-two FIR
// 11-tap symmetric lowpass from the coefficient ROM in the package,
// one multiplier per channel stepped through the taps sequentially

`timescale 1ns/1ns

module decimating_fir (
  input  logic                                    clock,
  input  logic                                    reset,
  input  logic                                    in_strobe,
  input  logic signed [receiver_pkg::stage_width-1:0] in_i,
  input  logic signed [receiver_pkg::stage_width-1:0] in_q,
  output logic                                    out_strobe,
  output logic signed [receiver_pkg::out_width-1:0]   out_i,
  output logic signed [receiver_pkg::out_width-1:0]   out_q
);

  import receiver_pkg::*;

  localparam int ACC_W = stage_width + coef_width;
  localparam int TAP_W = $clog2(fir_taps + 1);

  // Delay line, index 0 holds the newest sample
  logic signed [stage_width-1:0] line_i [fir_taps];
  logic signed [stage_width-1:0] line_q [fir_taps];
  logic signed [stage_width-1:0] pending_i;
  logic signed [stage_width-1:0] pending_q;

  logic                          phase;
  logic                          start;
  logic                          busy;
  logic        [TAP_W-1:0]       tap;
  logic        [TAP_W-1:0]       rom_addr;
  logic signed [coef_width-1:0]  coef;
  logic signed [ACC_W-1:0]       prod_i;
  logic signed [ACC_W-1:0]       prod_q;
  logic signed [ACC_W-1:0]       acc_i;
  logic signed [ACC_W-1:0]       acc_q;
  logic signed [ACC_W-1:0]       shift_i;
  logic signed [ACC_W-1:0]       shift_q;

  // Every second strobe starts a new output
  assign start = in_strobe && phase;

  // ------------------------------
  // Delay line
  // Odd sample waits in pending, both enter together on the even one
  // so the line stays still while the taps are read
  always_ff @(posedge clock) begin
    if (reset) begin
      phase     <= 1'b0;
      pending_i <= '0;
      pending_q <= '0;
      for (int k = 0; k < fir_taps; k++) begin
        line_i[k] <= '0;
        line_q[k] <= '0;
      end
    end else if (in_strobe) begin
      phase <= ~phase;
      if (!phase) begin
        pending_i <= in_i;
        pending_q <= in_q;
      end else begin
        line_i[0] <= in_i;
        line_q[0] <= in_q;
        line_i[1] <= pending_i;
        line_q[1] <= pending_q;
        for (int k = 2; k < fir_taps; k++) begin
          line_i[k] <= line_i[k-2];
          line_q[k] <= line_q[k-2];
        end
      end
    end
  end

  // ------------------------------
  // Coefficient ROM and multipliers
  assign rom_addr = (tap < TAP_W'(fir_taps)) ? tap : '0;
  assign coef     = fir_coefs[rom_addr];
  assign prod_i   = line_i[rom_addr] * coef;
  assign prod_q   = line_q[rom_addr] * coef;

  // Drop extra fraction bits, keep 8 below the input LSB
  assign shift_i = acc_i >>> fir_shift;
  assign shift_q = acc_q >>> fir_shift;

  // Taps 0 to 10 accumulate, tap 11 loads the result
  always_ff @(posedge clock) begin
    if (reset) begin
      busy       <= 1'b0;
      tap        <= '0;
      acc_i      <= '0;
      acc_q      <= '0;
      out_strobe <= 1'b0;
      out_i      <= '0;
      out_q      <= '0;
    end else begin
      out_strobe <= 1'b0;
      if (start) begin
        busy  <= 1'b1;
        tap   <= '0;
        acc_i <= '0;
        acc_q <= '0;
      end else if (busy) begin
        if (tap == TAP_W'(fir_taps)) begin
          busy       <= 1'b0;
          out_strobe <= 1'b1;
          out_i      <= shift_i[out_width-1:0];
          out_q      <= shift_q[out_width-1:0];
        end else begin
          acc_i <= acc_i + prod_i;
          acc_q <= acc_q + prod_q;
          tap   <= tap + 1'b1;
        end
      end
    end
  end

  // Upstream spacing must leave room for a full accumulation
  assert property (@(posedge clock) disable iff (reset) busy |-> !start);

endmodule

//--- source/receiver_chain.sv
// Receive chain top level
// Fixed CIC per channel, variable CIC per channel, then the
// decimate-by-two FIR with an optional output register

`timescale 1ns/1ns

module receiver_chain #(
  parameter int CIC_RATE        = 5,
  parameter int REGISTER_OUTPUT = 1
) (
  input  logic                                      clock,
  input  logic                                      reset,
  input  logic        [receiver_pkg::rate_width-1:0] rate,
  input  logic signed [receiver_pkg::mix_width-1:0]  mix_i,
  input  logic signed [receiver_pkg::mix_width-1:0]  mix_q,
  output logic                                      out_strobe,
  output logic signed [receiver_pkg::out_width-1:0]  out_i,
  output logic signed [receiver_pkg::out_width-1:0]  out_q
);

  import receiver_pkg::*;

  logic                          decim_a_strobe;
  logic signed [stage_width-1:0] decim_a_i;
  logic signed [stage_width-1:0] decim_a_q;
  logic                          decim_b_strobe;
  logic signed [stage_width-1:0] decim_b_i;
  logic signed [stage_width-1:0] decim_b_q;
  logic                          fir_strobe;
  logic signed [out_width-1:0]   fir_i;
  logic signed [out_width-1:0]   fir_q;

  // ------------------------------
  // Fixed CIC, one input per clock, Q strobe unused since both run in lockstep
  cic_decimator #(.STAGES(3), .DECIMATION(CIC_RATE), .IN_WIDTH(mix_width),
                  .OUT_WIDTH(stage_width))
    u_cic_i (.clock, .reset, .in_strobe(1'b1), .in_data(mix_i),
             .out_strobe(decim_a_strobe), .out_data(decim_a_i));

  cic_decimator #(.STAGES(3), .DECIMATION(CIC_RATE), .IN_WIDTH(mix_width),
                  .OUT_WIDTH(stage_width))
    u_cic_q (.clock, .reset, .in_strobe(1'b1), .in_data(mix_q),
             .out_strobe(), .out_data(decim_a_q));

  // Variable CIC, rate 2 to 16
  variable_cic_decimator #(.STAGES(5), .IN_WIDTH(stage_width), .OUT_WIDTH(stage_width))
    u_var_i (.clock, .reset, .in_strobe(decim_a_strobe), .rate, .in_data(decim_a_i),
             .out_strobe(decim_b_strobe), .out_data(decim_b_i));

  variable_cic_decimator #(.STAGES(5), .IN_WIDTH(stage_width), .OUT_WIDTH(stage_width))
    u_var_q (.clock, .reset, .in_strobe(decim_a_strobe), .rate, .in_data(decim_a_q),
             .out_strobe(), .out_data(decim_b_q));

  decimating_fir u_fir (.clock, .reset, .in_strobe(decim_b_strobe), .in_i(decim_b_i),
                        .in_q(decim_b_q), .out_strobe(fir_strobe), .out_i(fir_i),
                        .out_q(fir_q));

  // ------------------------------
  // Output stage, strobe delayed with the data when registered
  if (REGISTER_OUTPUT == 1) begin : g_out_reg
    always_ff @(posedge clock) begin
      if (reset) begin
        out_strobe <= 1'b0;
        out_i      <= '0;
        out_q      <= '0;
      end else begin
        out_strobe <= fir_strobe;
        out_i      <= fir_i;
        out_q      <= fir_q;
      end
    end
  end else begin : g_out_comb
    assign out_strobe = fir_strobe;
    assign out_i      = fir_i;
    assign out_q      = fir_q;
  end

endmodule

//--- tests/receiver_model.svh
// Bit-exact integer model of the receive chain, working on sample queues
// Generic CIC decimator, decimate-by-two FIR and the chain joining them

`ifndef RECEIVER_MODEL_SVH
`define RECEIVER_MODEL_SVH

typedef longint sample_q_t [$];

// Two's complement wrap of a value to the given width
function automatic longint wrap_bits(input longint value, input int width);
  return (value <<< (64 - width)) >>> (64 - width);
endfunction

// Smallest b with 2**b >= value
function automatic int ceil_log2(input int value);
  int bits;
  bits = 0;
  while ((1 << bits) < value) begin
    bits++;
  end
  return bits;
endfunction

// ------------------------------
// CIC with wrapping accumulators, output shifted and cut to stage_width
function automatic void cic_model(input sample_q_t din, input int stages, input int rate,
                                  input int acc_w, input int shift, output sample_q_t dout);
  longint integ [8];
  longint comb_mem [8];
  longint value;
  longint prev;
  int     count;
  dout  = {};
  count = 0;
  for (int s = 0; s < 8; s++) begin
    integ[s]    = 0;
    comb_mem[s] = 0;
  end
  foreach (din[n]) begin
    value = din[n];
    for (int s = 0; s < stages; s++) begin
      integ[s] = wrap_bits(integ[s] + value, acc_w);
      value    = integ[s];
    end
    count++;
    // Every rate-th input runs the combs
    if (count == rate) begin
      count = 0;
      for (int s = 0; s < stages; s++) begin
        prev        = comb_mem[s];
        comb_mem[s] = value;
        value       = wrap_bits(value - prev, acc_w);
      end
      dout.push_back(wrap_bits(value >>> shift, stage_width));
    end
  end
endfunction

// ------------------------------
// One output per odd input index, 34-bit accumulator
function automatic void fir_model(input sample_q_t din, output sample_q_t dout);
  longint acc;
  longint sample;
  dout = {};
  for (int n = 1; n < din.size(); n += 2) begin
    acc = 0;
    for (int t = 0; t < fir_taps; t++) begin
      sample = (n - t >= 0) ? din[n - t] : 0;
      acc    = wrap_bits(acc + sample * longint'(fir_coefs[t]), stage_width + coef_width);
    end
    dout.push_back(wrap_bits(acc >>> fir_shift, out_width));
  end
endfunction

// Fixed 3-stage CIC, 5-stage CIC at the runtime rate, then the FIR
function automatic void chain_model(input sample_q_t mix, input int cic_rate, input int rate,
                                    output sample_q_t result);
  sample_q_t after_fixed;
  sample_q_t after_var;
  int        fixed_acc;
  int        var_acc;
  fixed_acc = mix_width + ceil_log2(cic_rate ** 3);
  var_acc   = stage_width + 5 * ceil_log2(rate_max);
  cic_model(mix, 3, cic_rate, fixed_acc, fixed_acc - stage_width, after_fixed);
  cic_model(after_fixed, 5, rate, var_acc, 5 * ceil_log2(rate), after_var);
  fir_model(after_var, result);
endfunction

`endif

//--- tests/receiver_chain_tb.sv
// Testbench for the receive chain
// Random and constant I/Q streams at several rates, checked against
// the bit-exact model, with output capture and a watchdog

`timescale 1ns/1ns

module receiver_chain_tb;

  import receiver_pkg::*;

  `include "receiver_model.svh"

  localparam int cic_rate  = 5;
  localparam int num_tests = 7;
  localparam int dc_test   = 6;
  // Extra inputs so the last wanted output clears the pipeline
  localparam int drain     = 20;
  localparam int test_rate [num_tests] = '{3, 2, 16, 5, 11, 7, 4};
  localparam int test_outs [num_tests] = '{4, 40, 20, 20, 15, 30, 30};

  string test_names [num_tests] = '{"reset state", "rate 2", "rate 16", "rate 5",
                                     "rate 11", "output count", "dc input"};

  logic                         clock;
  logic                         reset;
  logic        [rate_width-1:0] rate;
  logic signed [mix_width-1:0]  mix_i;
  logic signed [mix_width-1:0]  mix_q;
  logic                         out_strobe;
  logic signed [out_width-1:0]  out_i;
  logic signed [out_width-1:0]  out_q;

  sample_q_t got_i;
  sample_q_t got_q;
  logic      last_strobe     = 1'b0;
  int        adjacent_pulses = 0;
  int        pass_count      = 0;
  int        fail_count      = 0;

  receiver_chain DUT (.clock, .reset, .rate, .mix_i, .mix_q, .out_strobe, .out_i, .out_q);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // ------------------------------
  // Outputs change on the rising edge and are read on the falling one
  always @(negedge clock) begin
    if (out_strobe) begin
      got_i.push_back(longint'(out_i));
      got_q.push_back(longint'(out_q));
      if (last_strobe) begin
        adjacent_pulses++;
      end
    end
    last_strobe = out_strobe;
  end

  task automatic compare_sample(input string signal, input longint expected,
                                input longint actual);
    logic [out_width-1:0] exp_bits;
    logic [out_width-1:0] act_bits;
    exp_bits = out_width'(expected);
    act_bits = out_width'(actual);
    assert (exp_bits == act_bits) pass_count++;
    else begin
      fail_count++;
      $display("FAIL %s expected %h actual %h", signal, exp_bits, act_bits);
    end
  endtask

  task automatic check_condition(input bit ok, input string what);
    assert (ok) pass_count++;
    else begin
      fail_count++;
      $display("Error: %s", what);
    end
  endtask

  // ------------------------------
  // Reset at the new rate, drive the stream and compare with the model
  task automatic run_test(input int t);
    sample_q_t in_i;
    sample_q_t in_q;
    sample_q_t exp_i;
    sample_q_t exp_q;
    int        period;
    int        n_in;
    int        start_fails;
    int        last;
    bit        idle;
    period      = 2 * cic_rate * test_rate[t];
    n_in        = test_outs[t] * period + drain;
    start_fails = fail_count;
    idle        = 1'b1;
    @(negedge clock);
    reset = 1'b1;
    rate  = rate_width'(test_rate[t]);
    repeat (4) @(negedge clock);
    got_i = {};
    got_q = {};
    adjacent_pulses = 0;
    reset = 1'b0;
    for (int n = 0; n < n_in; n++) begin
      // No output can be due within the first period
      if (n < period) begin
        idle &= (out_strobe == 1'b0) && (out_i == '0) && (out_q == '0);
      end
      if (t == dc_test) begin
        mix_i = 18'sd90000;
        mix_q = -18'sd60000;
      end else begin
        mix_i = mix_width'($urandom);
        mix_q = mix_width'($urandom);
      end
      in_i.push_back(longint'(mix_i));
      in_q.push_back(longint'(mix_q));
      @(negedge clock);
    end
    reset = 1'b1;
    repeat (2) @(negedge clock);
    chain_model(in_i, cic_rate, test_rate[t], exp_i);
    chain_model(in_q, cic_rate, test_rate[t], exp_q);
    check_condition(idle, "outputs left their reset values before the first output was due");
    check_condition(got_i.size() >= test_outs[t], "fewer output strobes than requested");
    check_condition(got_i.size() + 1 >= n_in / period && got_i.size() <= n_in / period + 1,
                    "output strobe count not within one of inputs over the decimation");
    check_condition(adjacent_pulses == 0, "out_strobe was high on adjacent cycles");
    for (int k = 0; k < got_i.size() && k < exp_i.size(); k++) begin
      compare_sample("out_i", exp_i[k], got_i[k]);
      compare_sample("out_q", exp_q[k], got_q[k]);
    end
    // Settled constant output keeps the sign of each input channel
    if (t == dc_test && got_i.size() >= 2) begin
      last = got_i.size() - 1;
      check_condition(got_i[last] == got_i[last - 1] && got_q[last] == got_q[last - 1],
                      "constant input did not settle to a constant output");
      check_condition(got_i[last] > 0, "out_i is not positive for a positive constant");
      check_condition(got_q[last] < 0, "out_q is not negative for a negative constant");
    end
    $display("Test %0d %s: rate %0d, %0d outputs, %0d errors", t + 1, test_names[t],
             test_rate[t], got_i.size(), fail_count - start_fails);
  endtask

  function automatic longint watchdog_cycles();
    longint total;
    total = 0;
    for (int t = 0; t < num_tests; t++) begin
      total += test_outs[t] * 2 * cic_rate * test_rate[t] + drain + 200;
    end
    return total;
  endfunction

  initial begin
    reset = 1'b1;
    rate  = rate_width'(rate_min);
    mix_i = '0;
    mix_q = '0;
    void'($urandom(17469));
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    longint limit;
    limit = watchdog_cycles();
    #(limit * 10);
    $display("Timeout: the run did not finish within %0d clock cycles", limit);
    $display("Checks failed");
    $finish;
  end

endmodule

//--- receiver_chain.f
+incdir+tests
source/receiver_pkg.sv
source/cic_decimator.sv
source/variable_cic_decimator.sv
source/decimating_fir.sv
source/receiver_chain.sv
tests/receiver_chain_tb.sv
